//--- mixer_engine.f
rtl/mix_isa_pkg.sv
rtl/mix_data_pkg.sv
rtl/mix_ram.sv
rtl/mix_decode.sv
rtl/mix_execute.sv
rtl/mix_result.sv
rtl/mixer_engine.sv
tb/mixer_engine_tb.sv

//--- Makefile
TOP := mixer_engine_tb

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build output"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		--top-module $(TOP) -f mixer_engine.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf obj_dir

//--- tb/mixer_engine_tb.sv
`timescale 1ns/1ps

module mixer_engine_tb;

    localparam int FRAME_W    = 3;
    localparam int CODE_W     = 6;
    localparam int AUDIO_W    = 4 + FRAME_W;
    localparam int RST_CYCLES = 10;
    localparam logic [6:0] OPC_HALT    = 7'h00;
    localparam logic [6:0] OPC_MAC     = 7'h40;
    localparam logic [6:0] OPC_MAC_CLR = 7'h41;
    localparam logic [6:0] OPC_OUT     = 7'h42;

    typedef struct packed {
        logic [3:0]  chan;
        logic [15:0] sample;
    } out_pair_t;

    logic               ck;
    logic               rst;
    logic               code_we;
    logic [CODE_W-1:0]  code_waddr;
    logic [31:0]        code_wdata;
    logic               audio_we;
    logic [AUDIO_W-1:0] audio_waddr;
    logic signed [15:0] audio_wdata;
    logic [FRAME_W-1:0] frame;
    logic               start;
    logic               out_we;
    logic [3:0]         out_chan;
    logic signed [15:0] out_sample;
    logic               done;
    logic               error;

    // Copies of both RAMs for the model
    logic [31:0]        prog [2**CODE_W];
    logic signed [15:0] audio [2**AUDIO_W];
    logic signed [39:0] model_acc = '0;
    out_pair_t          exp_q [$];
    out_pair_t          exp_pair;
    logic [15:0]        lfsr = 16'd9762;
    logic               busy = 1'b0;
    int                 prog_len = 0;
    int                 val_errs = 0;
    int                 misc_errs = 0;
    int                 cycles = 0;
    int                 cycle_limit = RST_CYCLES;

    mixer_engine #(.FRAME_W(FRAME_W), .CODE_W(CODE_W)) u_mixer_engine (.*);

    initial begin
        ck = 1'b0;
        forever #20 ck = ~ck;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] r;
        logic        fb;
        r = '0;
        for (int k = 0; k < n; k++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            r    = {r[14:0], fb};
        end
        return r;
    endfunction

    // Walks the program from word 0, queues expected outputs, returns the error flag
    function automatic logic run_model(input logic [FRAME_W-1:0] frm);
        logic [31:0]        w;
        logic [2:0]         shift;
        logic [AUDIO_W-1:0] addr;
        logic signed [39:0] prod;
        logic signed [39:0] win;
        int                 fidx;
        out_pair_t          pair;
        for (int i = 0; i < 2**CODE_W; i++) begin
            w     = prog[i];
            shift = w[18:16];
            fidx  = (frm + w[20:16]) % (2**FRAME_W);
            addr  = {w[24:21], fidx[FRAME_W-1:0]};
            prod  = $signed(w[15:0]) * audio[addr];
            win   = model_acc >>> (4 * shift);
            case (w[31:25])
                OPC_MAC: model_acc = model_acc + prod;
                OPC_MAC_CLR: model_acc = prod;
                OPC_OUT: begin
                    pair.chan   = w[24:21];
                    pair.sample = (shift == 3'd7) ? 16'h0000 : win[15:0];
                    exp_q.push_back(pair);
                end
                OPC_HALT: return 1'b0;
                default: return 1'b1;
            endcase
        end
        return 1'b1;
    endfunction

    task automatic check_bit(input string name, input logic expv, input logic got);
        assert (got === expv) else begin
            $display("[ERROR] %0t %s expected %0b got %0b", $time, name, expv, got);
            val_errs++;
        end
    endtask

    // Appends one word to the program being built
    task automatic add_instr(input logic [6:0] op, input logic [3:0] ch,
                             input logic [4:0] off, input logic [15:0] gain);
        prog[prog_len] = {op, ch, off, gain};
        code_waddr     = prog_len[CODE_W-1:0];
        code_wdata     = {op, ch, off, gain};
        code_we        = 1'b1;
        @(negedge ck);
        code_we  = 1'b0;
        prog_len = prog_len + 1;
    endtask

    task automatic run_program(input logic [FRAME_W-1:0] frm, input bit poke);
        logic exp_err;
        exp_err     = run_model(frm);
        cycle_limit = cycle_limit + prog_len + 10;
        frame       = frm;
        start       = 1'b1;
        busy        = 1'b1;
        @(negedge ck);
        start = 1'b0;
        if (poke) begin
            // Second start while running
            repeat (2) @(negedge ck);
            start = 1'b1;
            @(negedge ck);
            start = 1'b0;
        end
        while (!done) @(negedge ck);
        busy = 1'b0;
        check_bit("error", exp_err, error);
        repeat (3) @(negedge ck);
        check_bit("done", 1'b1, done);
        assert (exp_q.size() == 0) else begin
            $display("%0t run ended with %0d expected outputs missing", $time, exp_q.size());
            misc_errs++;
            exp_q.delete();
        end
    endtask

    always @(negedge ck) begin
        if (rst && out_we) begin
            assert (exp_q.size() > 0) else begin
                $display("%0t output strobe with nothing expected", $time);
                misc_errs++;
            end
            if (exp_q.size() > 0) begin
                exp_pair = exp_q.pop_front();
                assert (out_chan == exp_pair.chan) else begin
                    $display("[ERROR] %0t out_chan expected %0d got %0d",
                             $time, exp_pair.chan, out_chan);
                    val_errs++;
                end
                assert (out_sample == exp_pair.sample) else begin
                    $display("[ERROR] %0t out_sample expected %04h got %04h",
                             $time, exp_pair.sample, out_sample);
                    val_errs++;
                end
            end
        end
    end

    // Counts reset and run cycles only
    always @(posedge ck) begin
        if (!rst || busy) begin
            cycles = cycles + 1;
        end
        if (cycles > cycle_limit) begin
            $display("Timeout, no done after %0d counted cycles", cycles);
            $display("Errors: %0d value, %0d other", val_errs, misc_errs + 1);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        logic [3:0]         ch;
        logic [4:0]         off;
        logic [FRAME_W-1:0] fi;
        logic [15:0]        g;
        rst         = 1'b0;
        start       = 1'b0;
        code_we     = 1'b0;
        code_waddr  = '0;
        code_wdata  = '0;
        audio_we    = 1'b0;
        audio_waddr = '0;
        audio_wdata = '0;
        frame       = '0;
        repeat (RST_CYCLES) @(negedge ck);
        rst = 1'b1;
        @(negedge ck);
        check_bit("out_we", 1'b0, out_we);
        check_bit("done", 1'b0, done);
        check_bit("error", 1'b0, error);
        for (int a = 0; a < 2**AUDIO_W; a++) begin
            audio[a]    = rand_bits(16);
            audio_waddr = a[AUDIO_W-1:0];
            audio_wdata = audio[a];
            audio_we    = 1'b1;
            @(negedge ck);
        end
        audio_we = 1'b0;
        check_bit("done", 1'b0, done);

        // One product per channel, then every window shift
        for (int base = 0; base < 16; base += 4) begin
            prog_len = 0;
            for (int c = base; c < base + 4; c++) begin
                add_instr(OPC_MAC_CLR, 4'(c), 5'(rand_bits(5)), rand_bits(16));
                for (int s = 0; s < 8; s++) begin
                    add_instr(OPC_OUT, 4'(c), 5'(s), 16'h0000);
                end
            end
            add_instr(OPC_HALT, 4'h0, 5'h00, 16'h0000);
            run_program(FRAME_W'(base), 1'b0);
        end

        // Long chains where every product of the second one is negative
        for (int pass = 0; pass < 2; pass++) begin
            prog_len = 0;
            add_instr(OPC_MAC_CLR, 4'(rand_bits(4)), 5'(rand_bits(5)), rand_bits(16));
            for (int k = 0; k < 40; k++) begin
                ch  = 4'(rand_bits(4));
                off = 5'(rand_bits(5));
                fi  = FRAME_W'(3 + 2 * pass) + off[FRAME_W-1:0];
                g   = (pass == 1) ? -audio[{ch, fi}] : rand_bits(16);
                add_instr(OPC_MAC, ch, off, g);
                if (k % 5 == 4) begin
                    add_instr(OPC_OUT, 4'(rand_bits(4)), 5'(rand_bits(3)), 16'h0000);
                end
            end
            add_instr(OPC_HALT, 4'h0, 5'h00, 16'h0000);
            run_program(FRAME_W'(3 + 2 * pass), pass == 1);
        end

        // Words after a halt never issue
        prog_len = 0;
        add_instr(OPC_MAC_CLR, 4'h2, 5'h01, 16'h0100);
        add_instr(OPC_OUT, 4'h9, 5'h01, 16'h0000);
        add_instr(OPC_HALT, 4'h0, 5'h00, 16'h0000);
        add_instr(OPC_OUT, 4'h9, 5'h00, 16'h0000);
        add_instr(OPC_MAC_CLR, 4'h3, 5'h00, 16'h0001);
        add_instr(OPC_OUT, 4'h4, 5'h00, 16'h0000);
        run_program(FRAME_W'(2), 1'b0);

        // Illegal opcode at word 2
        prog_len = 0;
        add_instr(OPC_MAC, 4'h5, 5'h06, 16'h7fff);
        add_instr(OPC_OUT, 4'h1, 5'h02, 16'h0000);
        add_instr(7'h13, 4'h0, 5'h00, 16'h0000);
        add_instr(OPC_OUT, 4'h1, 5'h00, 16'h0000);
        add_instr(OPC_HALT, 4'h0, 5'h00, 16'h0000);
        run_program(FRAME_W'(2), 1'b0);

        // Unit gain reads raw words and offsets wrap past the last frame
        prog_len = 0;
        for (int o = 0; o < 10; o++) begin
            add_instr(OPC_MAC_CLR, 4'(o + 3), 5'(o * 3), 16'h0001);
            add_instr(OPC_OUT, 4'(o), 5'h00, 16'h0000);
        end
        add_instr(OPC_HALT, 4'h0, 5'h00, 16'h0000);
        run_program(FRAME_W'(6), 1'b0);
        run_program(FRAME_W'(1), 1'b1);

        $display("Errors: %0d value, %0d other", val_errs, misc_errs);
        if (val_errs + misc_errs == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- rtl/mixer_engine.sv
`timescale 1ns/1ps

module mixer_engine #(
    parameter int FRAME_W = 3,
    parameter int CODE_W  = 6
) (
    input  logic                                   ck,
    input  logic                                   rst,
    input  logic                                   code_we,
    input  logic [CODE_W-1:0]                      code_waddr,
    input  mix_isa_pkg::instr_t                    code_wdata,
    input  logic                                   audio_we,
    input  logic [mix_isa_pkg::CHAN_W+FRAME_W-1:0] audio_waddr,
    input  mix_data_pkg::sample_t                  audio_wdata,
    input  logic [FRAME_W-1:0]                     frame,
    input  logic                                   start,
    output logic                                   out_we,
    output logic [mix_isa_pkg::CHAN_W-1:0]         out_chan,
    output mix_data_pkg::sample_t                  out_sample,
    output logic                                   done,
    output logic                                   error
);

    import mix_isa_pkg::*;
    import mix_data_pkg::*;

    // 16 channels of 2^FRAME_W frames
    localparam int AUDIO_W = CHAN_W + FRAME_W;

    logic [CODE_W-1:0]  code_raddr;
    instr_t             code_rdata;
    logic [AUDIO_W-1:0] audio_raddr;
    sample_t            audio_rdata;
    dec_op_t            dec;
    exe_op_t            exe;

    mix_ram #(.BITS($bits(instr_t)), .DEPTH_W(CODE_W)) u_code_ram (
        .ck    (ck),
        .we    (code_we),
        .waddr (code_waddr),
        .wdata (code_wdata),
        .raddr (code_raddr),
        .rdata (code_rdata)
    );

    mix_ram #(.BITS($bits(sample_t)), .DEPTH_W(AUDIO_W)) u_audio_ram (
        .ck    (ck),
        .we    (audio_we),
        .waddr (audio_waddr),
        .wdata (audio_wdata),
        .raddr (audio_raddr),
        .rdata (audio_rdata)
    );

    mix_decode #(.CODE_W(CODE_W)) u_decode (
        .ck         (ck),
        .rst        (rst),
        .start      (start),
        .code_raddr (code_raddr),
        .code_rdata (code_rdata),
        .dec        (dec),
        .done       (done),
        .error      (error)
    );

    mix_execute #(.FRAME_W(FRAME_W)) u_execute (
        .ck          (ck),
        .rst         (rst),
        .frame       (frame),
        .dec         (dec),
        .audio_raddr (audio_raddr),
        .audio_rdata (audio_rdata),
        .exe         (exe)
    );

    mix_result u_result (
        .ck         (ck),
        .rst        (rst),
        .exe        (exe),
        .out_we     (out_we),
        .out_chan   (out_chan),
        .out_sample (out_sample)
    );

endmodule

//--- rtl/mix_result.sv
`timescale 1ns/1ps

module mix_result (
    input  logic                           ck,
    input  logic                           rst,
    input  mix_data_pkg::exe_op_t          exe,
    output logic                           out_we,
    output logic [mix_isa_pkg::CHAN_W-1:0] out_chan,
    output mix_data_pkg::sample_t          out_sample
);

    import mix_isa_pkg::*;
    import mix_data_pkg::*;

    // Top shift code gives silence
    localparam logic [SHIFT_W-1:0] SHIFT_MUTE = '1;

    logic    emit;
    sample_t window;

    assign emit = exe.valid && exe.op == OP_OUT;

    // Window acc[4s+15:4s]
    always_comb begin
        if (exe.shift == SHIFT_MUTE) begin
            window = '0;
        end else begin
            window = exe.acc[4*exe.shift +: SAMPLE_W];
        end
    end

    always_ff @(posedge ck) begin
        if (!rst) begin
            out_we <= 1'b0;
        end else begin
            out_we <= emit;
        end
    end

    always_ff @(posedge ck) begin
        if (emit) begin
            out_chan   <= exe.chan;
            out_sample <= window;
        end
    end

    a_out_known: assert property (
        @(posedge ck) disable iff (!rst)
        !$isunknown(out_we) && (!out_we || !$isunknown({out_chan, out_sample}))
    );

endmodule

//--- rtl/mix_execute.sv
`timescale 1ns/1ps

module mix_execute #(
    parameter int FRAME_W = 3
) (
    input  logic                                   ck,
    input  logic                                   rst,
    input  logic [FRAME_W-1:0]                     frame,
    input  mix_data_pkg::dec_op_t                  dec,
    output logic [mix_isa_pkg::CHAN_W+FRAME_W-1:0] audio_raddr,
    input  mix_data_pkg::sample_t                  audio_rdata,
    output mix_data_pkg::exe_op_t                  exe
);

    import mix_isa_pkg::*;
    import mix_data_pkg::*;

    dec_op_t            op_a;
    dec_op_t            op_b;
    prod_t              prod;
    acc_t               acc;
    acc_t               prod_ext;
    acc_t               acc_next;
    logic               is_mac;
    logic [FRAME_W-1:0] frame_idx;

    // Offset wraps inside the channel's block of frames
    assign frame_idx   = frame + dec.offset[FRAME_W-1:0];
    assign audio_raddr = {dec.chan, frame_idx};

    // op_a meets audio_rdata, op_b meets prod
    always_ff @(posedge ck) begin
        if (!rst) begin
            op_a <= '0;
            op_b <= '0;
        end else begin
            op_a <= dec;
            op_b <= op_a;
        end
    end

    always_ff @(posedge ck) begin
        prod <= $signed(op_a.gain) * audio_rdata;
    end

    assign is_mac   = op_b.valid && (op_b.op == OP_MAC || op_b.op == OP_MAC_CLR);
    assign prod_ext = {{(ACC_W-PROD_W){prod[PROD_W-1]}}, prod};

    // Wraps at 40 bits
    always_comb begin
        acc_next = acc;
        if (is_mac) begin
            if (op_b.op == OP_MAC_CLR) begin
                acc_next = prod_ext;
            end else begin
                acc_next = acc + prod_ext;
            end
        end
    end

    always_ff @(posedge ck) begin
        if (!rst) begin
            acc <= '0;
            exe <= '0;
        end else begin
            acc       <= acc_next;
            exe.valid <= op_b.valid;
            exe.op    <= op_b.op;
            exe.chan  <= op_b.chan;
            exe.shift <= op_b.offset[SHIFT_W-1:0];
            // OP_OUT sees the sum of every earlier MAC
            exe.acc   <= acc_next;
        end
    end

    // The op reaching the accumulator was decoded two cycles earlier
    a_acc_only_on_mac: assert property (
        @(posedge ck) disable iff (!rst)
        !($past(dec.valid, 2) &&
          ($past(dec.op, 2) == OP_MAC || $past(dec.op, 2) == OP_MAC_CLR))
        |=> $stable(acc)
    );

endmodule

//--- rtl/mix_decode.sv
`timescale 1ns/1ps

module mix_decode #(
    parameter int CODE_W = 6
) (
    input  logic                  ck,
    input  logic                  rst,
    input  logic                  start,
    output logic [CODE_W-1:0]     code_raddr,
    input  mix_isa_pkg::instr_t   code_rdata,
    output mix_data_pkg::dec_op_t dec,
    output logic                  done,
    output logic                  error
);

    import mix_isa_pkg::*;
    import mix_data_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DRAIN
    } state_e;

    // Stop seen at h+1, done at h+6 once the last op has left result
    localparam logic [2:0] DRAIN_LAST = 3'd3;

    state_e            state;
    logic [CODE_W-1:0] pc;
    logic              fetch_vld;
    logic [2:0]        drain_cnt;
    logic              err_pend;
    logic              is_exec;
    logic              illegal;
    logic              stop;

    assign code_raddr = pc;

    always_comb begin
        is_exec = 1'b0;
        illegal = 1'b0;
        case (code_rdata.opcode)
            OP_MAC, OP_MAC_CLR, OP_OUT: is_exec = 1'b1;
            OP_HALT: is_exec = 1'b0;
            default: illegal = 1'b1;
        endcase
    end

    // Halt or illegal word just fetched
    assign stop = fetch_vld && !is_exec;

    always_ff @(posedge ck) begin
        if (!rst) begin
            state     <= IDLE;
            pc        <= '0;
            fetch_vld <= 1'b0;
            drain_cnt <= '0;
            err_pend  <= 1'b0;
            done      <= 1'b0;
            error     <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    // pc is 0 here, so word 0 is already being read
                    if (start) begin
                        state     <= RUN;
                        pc        <= pc + 1'b1;
                        fetch_vld <= 1'b1;
                        err_pend  <= 1'b0;
                        done      <= 1'b0;
                        error     <= 1'b0;
                    end
                end
                RUN: begin
                    if (stop) begin
                        state     <= DRAIN;
                        fetch_vld <= 1'b0;
                        err_pend  <= illegal;
                        drain_cnt <= '0;
                    end else begin
                        pc <= pc + 1'b1;
                    end
                end
                default: begin
                    if (drain_cnt == DRAIN_LAST) begin
                        state <= IDLE;
                        pc    <= '0;
                        done  <= 1'b1;
                        error <= err_pend;
                    end else begin
                        drain_cnt <= drain_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge ck) begin
        if (!rst) begin
            dec <= '0;
        end else begin
            dec.valid  <= fetch_vld && is_exec;
            dec.op     <= op_e'(code_rdata.opcode);
            dec.chan   <= code_rdata.chan;
            dec.offset <= code_rdata.offset;
            dec.gain   <= code_rdata.gain;
        end
    end

    a_idle_no_valid: assert property (
        @(posedge ck) disable iff (!rst) state == IDLE |-> !dec.valid
    );

    // Done comes five cycles after the stop word and flags it if illegal
    a_error_with_done: assert property (
        @(posedge ck) disable iff (!rst)
        $rose(done) |-> error == $past(stop && illegal, 5)
    );

endmodule

//--- rtl/mix_ram.sv
`timescale 1ns/1ps

module mix_ram #(
    parameter int BITS    = 16,
    parameter int DEPTH_W = 7
) (
    input  logic               ck,
    input  logic               we,
    input  logic [DEPTH_W-1:0] waddr,
    input  logic [BITS-1:0]    wdata,
    input  logic [DEPTH_W-1:0] raddr,
    output logic [BITS-1:0]    rdata
);

    logic [BITS-1:0] mem [2**DEPTH_W];

    always_ff @(posedge ck) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Registered read, old word on a same-address write
    always_ff @(posedge ck) begin
        rdata <= mem[raddr];
    end

endmodule

//--- rtl/mix_data_pkg.sv
package mix_data_pkg;

    import mix_isa_pkg::*;

    localparam int SAMPLE_W = 16;
    localparam int PROD_W   = 2 * SAMPLE_W;
    localparam int ACC_W    = 40;

    typedef logic signed [SAMPLE_W-1:0] sample_t;
    typedef logic signed [PROD_W-1:0]   prod_t;
    typedef logic signed [ACC_W-1:0]    acc_t;

    // Decode to execute
    typedef struct packed {
        logic                valid;
        op_e                 op;
        logic [CHAN_W-1:0]   chan;
        logic [OFFSET_W-1:0] offset;
        logic [GAIN_W-1:0]   gain;
    } dec_op_t;

    // Execute to result, acc is the value after this op
    typedef struct packed {
        logic               valid;
        op_e                op;
        logic [CHAN_W-1:0]  chan;
        logic [SHIFT_W-1:0] shift;
        acc_t               acc;
    } exe_op_t;

endpackage

//--- rtl/mix_isa_pkg.sv
package mix_isa_pkg;

    // Field widths of the fixed 32-bit instruction word
    localparam int OPC_W    = 7;
    localparam int CHAN_W   = 4;
    localparam int OFFSET_W = 5;
    localparam int SHIFT_W  = 3;
    localparam int GAIN_W   = 16;

    typedef enum logic [OPC_W-1:0] {
        OP_HALT    = 7'h00,
        // Accumulate
        OP_MAC     = 7'h40,
        // Clear, then accumulate
        OP_MAC_CLR = 7'h41,
        // Emit a window of the accumulator
        OP_OUT     = 7'h42
    } op_e;

    // Opcode kept raw so illegal codes reach the decoder intact
    // For OP_OUT the low bits of offset hold the shift
    typedef struct packed {
        logic [OPC_W-1:0]    opcode;
        logic [CHAN_W-1:0]   chan;
        logic [OFFSET_W-1:0] offset;
        logic [GAIN_W-1:0]   gain;
    } instr_t;

endpackage
